/* common/max7219_macros.svh */
// max7219 driver constants
// sck rate, frame size and sequencing counts

`ifndef MAX7219_MACROS_SVH
`define MAX7219_MACROS_SVH

// clk cycles per sck half period, 2 or more
// 5 gives one sck period per 10 clk
`define MAX_SCK_HALF 5

// bits per serial frame, address byte then data byte
`define MAX_FRAME_BITS 16

// configuration frames sent once after reset
`define MAX_INIT_FRAMES 6

// digits scanned on the display module
`define MAX_DIGITS 8

`endif

/* common/max7219_pkg.sv */
// shared types for the max7219 display driver
// register addresses, frame layout and sequencer states

package max7219_pkg;

   // chip register map, sent as the first byte of a frame
   typedef enum logic [7:0] {
      reg_nop          = 8'h00,
      reg_digit0       = 8'h01,
      reg_digit1       = 8'h02,
      reg_digit2       = 8'h03,
      reg_digit3       = 8'h04,
      reg_digit4       = 8'h05,
      reg_digit5       = 8'h06,
      reg_digit6       = 8'h07,
      reg_digit7       = 8'h08,
      reg_decode_mode  = 8'h09,
      reg_intensity    = 8'h0a,
      reg_scan_limit   = 8'h0b,
      reg_shutdown     = 8'h0c,
      reg_display_test = 8'h0f
   } reg_addr_e;

   // one 16-bit frame, addr goes out first, msb first
   typedef struct packed {
      reg_addr_e   addr;
      logic [7:0]  data;
   } frame_t;

   // sequencer states
   typedef enum logic [1:0] {
      st_start,   // entry after reset
      st_shift,   // frame on the wire
      st_load,    // load strobe to the chip
      st_next     // step to the next frame
   } seq_state_e;

endpackage

/* logic/sck_timer.sv */
// sck half-period timer
// ticks every MAX_SCK_HALF clk while a shift runs
`timescale 1ns/1ps
`include "max7219_macros.svh"

module sck_timer (
   input  logic clk,
   input  logic rst_n,
   input  logic busy,
   output logic tick
);

   localparam int               CNT_W  = $clog2(`MAX_SCK_HALF);
   localparam logic [CNT_W-1:0] RELOAD = CNT_W'(`MAX_SCK_HALF - 1);

   logic [CNT_W-1:0] cnt;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt <= RELOAD;
      end else if (!busy || cnt == '0) begin
         cnt <= RELOAD;               // idle or end of a half period
      end else begin
         cnt <= cnt - 1'b1;
      end
   end

   // first tick lands MAX_SCK_HALF cycles after busy rises
   assign tick = busy && (cnt == '0);

endmodule

/* logic/frame_source.sv */
// frame source for the max7219 driver
// walks the init table, then scans digits 1 to 8 of a latched value
`timescale 1ns/1ps
`include "max7219_macros.svh"

module frame_source (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                frame_next,
   input  logic [31:0]         display_value,
   output max7219_pkg::frame_t frame
);

   localparam int PTR_W = $clog2(`MAX_INIT_FRAMES);
   localparam int DIG_W = $clog2(`MAX_DIGITS + 1);
   localparam int NIB_W = $clog2(`MAX_DIGITS);

   logic [PTR_W-1:0]    init_ptr;
   logic                in_scan;
   logic [DIG_W-1:0]    digit;          // chip digit, 1 to 8
   logic [31:0]         value_q;
   logic                to_digit1;
   logic [NIB_W-1:0]    nib_sel;
   logic [3:0]          nibble;
   logic [6:0]          seg;            // a..g on bits 6..0
   max7219_pkg::frame_t init_frame;

   assign to_digit1 = frame_next && (in_scan ? (digit == DIG_W'(`MAX_DIGITS))
                                             : (init_ptr == PTR_W'(`MAX_INIT_FRAMES - 1)));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         init_ptr <= '0;
         in_scan  <= 1'b0;
         digit    <= DIG_W'(1);
      end else if (to_digit1) begin
         in_scan <= 1'b1;
         digit   <= DIG_W'(1);
      end else if (frame_next) begin
         if (in_scan) begin
            digit <= digit + 1'b1;
         end else begin
            init_ptr <= init_ptr + 1'b1;
         end
      end
   end

   // one value per scan, taken as digit 1 comes up
   always_ff @(posedge clk) begin
      if (to_digit1) begin
         value_q <= display_value;
      end
   end

   always_comb begin
      init_frame = '{addr: max7219_pkg::reg_nop, data: 8'h00};
      case (init_ptr)
         1: init_frame = '{addr: max7219_pkg::reg_display_test, data: 8'h00};
         2: init_frame = '{addr: max7219_pkg::reg_scan_limit, data: 8'h07};  // all 8 digits
         3: init_frame = '{addr: max7219_pkg::reg_decode_mode, data: 8'h00}; // raw segments
         4: init_frame = '{addr: max7219_pkg::reg_shutdown, data: 8'h01};    // normal operation
         5: init_frame = '{addr: max7219_pkg::reg_intensity, data: 8'h07};
         default: init_frame = '{addr: max7219_pkg::reg_nop, data: 8'h00};
      endcase
   end

   assign nib_sel = NIB_W'(digit - 1'b1);
   assign nibble  = value_q[{nib_sel, 2'b00} +: 4];

   always_comb begin
      case (nibble)
         4'h0: seg = 7'h7e;
         4'h1: seg = 7'h30;
         4'h2: seg = 7'h6d;
         4'h3: seg = 7'h79;
         4'h4: seg = 7'h33;
         4'h5: seg = 7'h5b;
         4'h6: seg = 7'h5f;
         4'h7: seg = 7'h70;
         4'h8: seg = 7'h7f;
         4'h9: seg = 7'h7b;
         4'ha: seg = 7'h77;
         4'hb: seg = 7'h1f;
         4'hc: seg = 7'h4e;
         4'hd: seg = 7'h3d;
         4'he: seg = 7'h4f;
         default: seg = 7'h47;   // F
      endcase
   end

   always_comb begin
      if (in_scan) begin
         frame.addr = max7219_pkg::reg_addr_e'(8'(digit));  // digit k is register k
         frame.data = {1'b0, seg};                         // decimal point off
      end else begin
         frame = init_frame;
      end
   end

   a_digit_range : assert property (
      @(posedge clk) disable iff (!rst_n)
      (digit >= DIG_W'(1)) && (digit <= DIG_W'(`MAX_DIGITS))
   ) else $error("digit counter left the range 1 to 8");

endmodule

/* max7219/frame_shifter.sv */
// serial shifter for one max7219 frame
// sends 16 bits msb first on din, chip samples on the rising sck edge
`timescale 1ns/1ps
`include "max7219_macros.svh"

module frame_shifter (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                shift_start,
   input  max7219_pkg::frame_t frame,
   input  logic                tick,
   output logic                busy,
   output logic                shift_done,
   output logic                max_din,
   output logic                max_clk
);

   localparam int FB    = `MAX_FRAME_BITS;
   localparam int CNT_W = $clog2(FB);

   logic [FB-1:0]    frame_bits;
   logic [FB-1:0]    shift_q;       // bits still to send, next one at FB-2
   logic [CNT_W-1:0] bit_cnt;
   logic             last_bit;
   logic             fall_tick;     // sck high to low, next bit goes out

   assign frame_bits = frame;
   assign last_bit   = (bit_cnt == CNT_W'(FB - 1));
   assign fall_tick  = busy && tick && max_clk;

   always_ff @(posedge clk) begin
      if (shift_start && !busy) begin
         shift_q <= frame_bits;
      end else if (fall_tick) begin
         shift_q <= shift_q << 1;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy       <= 1'b0;
         shift_done <= 1'b0;
         max_din    <= 1'b0;
         max_clk    <= 1'b0;
         bit_cnt    <= '0;
      end else begin
         shift_done <= 1'b0;
         if (!busy) begin
            if (shift_start) begin
               busy    <= 1'b1;
               bit_cnt <= '0;
               max_din <= frame_bits[FB-1];   // msb set up during first low phase
            end
         end else if (tick) begin
            if (!max_clk) begin
               max_clk <= 1'b1;
            end else begin
               max_clk <= 1'b0;
               if (last_bit) begin
                  busy       <= 1'b0;
                  shift_done <= 1'b1;
                  max_din    <= 1'b0;
               end else begin
                  bit_cnt <= bit_cnt + 1'b1;
                  max_din <= shift_q[FB-2];
               end
            end
         end
      end
   end

   // sck idles low between frames
   a_sck_idle_low : assert property (
      @(posedge clk) disable iff (!rst_n)
      !busy |-> !max_clk
   ) else $error("max_clk high while the shifter is idle");

endmodule

/* max7219/max7219_seq.sv */
// frame sequencer for the max7219 link
// starts each shift, strobes load when it ends and steps the frame source
`timescale 1ns/1ps

module max7219_seq (
   input  logic clk,
   input  logic rst_n,
   input  logic shift_done,
   input  logic busy,
   output logic shift_start,
   output logic frame_next,
   output logic max_load
);

   max7219_pkg::seq_state_e state;
   max7219_pkg::seq_state_e state_nxt;
   logic                    shift_start_nxt;
   logic                    frame_next_nxt;
   logic                    max_load_nxt;

   // outputs are registered, so each strobe is set one state early
   always_comb begin
      state_nxt       = state;
      shift_start_nxt = 1'b0;
      frame_next_nxt  = 1'b0;
      max_load_nxt    = 1'b0;

      case (state)
         max7219_pkg::st_start: begin
            // frame source already shows init frame 0
            shift_start_nxt = 1'b1;
            state_nxt       = max7219_pkg::st_shift;
         end

         max7219_pkg::st_shift: begin
            if (shift_done) begin
               max_load_nxt = 1'b1;      // latch the 16 bits in the chip
               state_nxt    = max7219_pkg::st_load;
            end
         end

         max7219_pkg::st_load: begin
            frame_next_nxt = 1'b1;
            state_nxt      = max7219_pkg::st_next;
         end

         max7219_pkg::st_next: begin
            // frame source steps at the end of this cycle,
            // so the shifter sees the new frame with the start pulse
            shift_start_nxt = 1'b1;
            state_nxt       = max7219_pkg::st_shift;
         end

         default: begin
            state_nxt = max7219_pkg::st_start;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state       <= max7219_pkg::st_start;
         shift_start <= 1'b0;
         frame_next  <= 1'b0;
         max_load    <= 1'b0;
      end else begin
         state       <= state_nxt;
         shift_start <= shift_start_nxt;
         frame_next  <= frame_next_nxt;
         max_load    <= max_load_nxt;
      end
   end

   // load strobe must fall between frames, never during a shift
   a_load_not_busy : assert property (
      @(posedge clk) disable iff (!rst_n)
      max_load |-> !busy
   ) else $error("max_load raised while the shifter is busy");

   // a start during a shift would be lost by the shifter
   a_start_when_idle : assert property (
      @(posedge clk) disable iff (!rst_n)
      shift_start |-> !busy
   ) else $error("shift_start fired while the shifter is busy");

endmodule

/* max7219/max7219_display.sv */
// max7219 eight-digit display driver
// sends the init frames, then scans a 32-bit value as hex digits
`timescale 1ns/1ps

module max7219_display (
   input  logic        clk,
   input  logic        rst_n,
   input  logic [31:0] display_value,
   output logic        max_din,
   output logic        max_clk,
   output logic        max_load
);

   logic                 shift_start;
   logic                 shift_done;
   logic                 busy;
   logic                 tick;
   logic                 frame_next;
   max7219_pkg::frame_t  frame;      // current frame, held as a level

   max7219_seq max7219_seq_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .shift_done  (shift_done),
      .busy        (busy),
      .shift_start (shift_start),
      .frame_next  (frame_next),
      .max_load    (max_load)
   );

   frame_shifter frame_shifter_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .shift_start (shift_start),
      .frame       (frame),
      .tick        (tick),
      .busy        (busy),
      .shift_done  (shift_done),
      .max_din     (max_din),
      .max_clk     (max_clk)
   );

   sck_timer sck_timer_i (
      .clk   (clk),
      .rst_n (rst_n),
      .busy  (busy),
      .tick  (tick)
   );

   frame_source frame_source_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .frame_next    (frame_next),
      .display_value (display_value),
      .frame         (frame)
   );

endmodule

/* test/tb_max7219_checks.svh */
// typed compare tasks for the max7219 testbench
// frames, sequencer state, single bits and counts
`ifndef TB_MAX7219_CHECKS_SVH
`define TB_MAX7219_CHECKS_SVH

int check_count = 0;
int error_count = 0;

task automatic check_frame(input string name, input max7219_pkg::frame_t got,
                           input max7219_pkg::frame_t exp);
   check_count++;
   if (got !== exp) begin
      error_count++;
      $display("[ERROR] time %0t %s got addr %h data %h expected addr %h data %h",
               $time, name, got.addr, got.data, exp.addr, exp.data);
   end
endtask

// state is read straight out of the sequencer
task automatic check_state(input max7219_pkg::seq_state_e exp);
   max7219_pkg::seq_state_e got;
   got = max7219_display_i.max7219_seq_i.state;
   check_count++;
   if (got !== exp) begin
      error_count++;
      $display("[ERROR] time %0t seq state got %s expected %s",
               $time, got.name(), exp.name());
   end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
   check_count++;
   if (got !== exp) begin
      error_count++;
      $display("[ERROR] time %0t %s got %b expected %b", $time, name, got, exp);
   end
endtask

task automatic check_int(input string name, input int got, input int exp);
   check_count++;
   if (got != exp) begin
      error_count++;
      $display("[ERROR] time %0t %s got %0d expected %0d", $time, name, got, exp);
   end
endtask

`endif

/* test/tb_max7219.sv */
// testbench for the max7219 display driver
// monitors the serial link and checks init, scan, tearing and timing
`timescale 1ns/1ps
`include "max7219_macros.svh"

module tb_max7219;

   localparam int FRAME_TIMEOUT = 40 * `MAX_SCK_HALF + 50;   // clk cycles per frame wait

   logic        clk = 1'b0;
   logic        rst_n;
   logic [31:0] display_value;
   logic        max_din;
   logic        max_clk;
   logic        max_load;
   logic        dut_busy;
   logic [31:0] lfsr_state = 32'hac67;

   // monitor state and timing stats
   max7219_pkg::frame_t frame_q[$];
   logic [`MAX_FRAME_BITS-1:0] shreg;
   logic prev_sck;
   logic prev_busy;
   logic prev_load;
   int   run_len;
   int   rise_cnt;
   int   load_len;
   int   high_min;
   int   high_max;
   int   low_min;
   int   low_max;
   int   rise_min;
   int   rise_max;
   int   load_min;
   int   load_max;
   int   load_overlap;

   `include "tb_max7219_checks.svh"

   max7219_display max7219_display_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .display_value (display_value),
      .max_din       (max_din),
      .max_clk       (max_clk),
      .max_load      (max_load)
   );

   assign dut_busy = max7219_display_i.busy;

   initial begin
      forever #2 clk = ~clk;
   end

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] r;
      int          i;
      r = '0;
      for (i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         r = {r[30:0], lfsr_state[0]};
      end
      return r;
   endfunction

   function automatic logic [6:0] seg_pattern(input logic [3:0] nib);
      case (nib)
         4'h0: return 7'h7e;
         4'h1: return 7'h30;
         4'h2: return 7'h6d;
         4'h3: return 7'h79;
         4'h4: return 7'h33;
         4'h5: return 7'h5b;
         4'h6: return 7'h5f;
         4'h7: return 7'h70;
         4'h8: return 7'h7f;
         4'h9: return 7'h7b;
         4'ha: return 7'h77;
         4'hb: return 7'h1f;
         4'hc: return 7'h4e;
         4'hd: return 7'h3d;
         4'he: return 7'h4f;
         default: return 7'h47;
      endcase
   endfunction

   function automatic max7219_pkg::frame_t init_frame_exp(input int i);
      case (i)
         1: return '{addr: max7219_pkg::reg_display_test, data: 8'h00};
         2: return '{addr: max7219_pkg::reg_scan_limit, data: 8'h07};
         3: return '{addr: max7219_pkg::reg_decode_mode, data: 8'h00};
         4: return '{addr: max7219_pkg::reg_shutdown, data: 8'h01};
         5: return '{addr: max7219_pkg::reg_intensity, data: 8'h07};
         default: return '{addr: max7219_pkg::reg_nop, data: 8'h00};
      endcase
   endfunction

   function automatic max7219_pkg::frame_t digit_frame(input logic [31:0] value, input int d);
      max7219_pkg::frame_t f;
      f.addr = max7219_pkg::reg_addr_e'(8'(d));
      f.data = {1'b0, seg_pattern(value[4*(d-1) +: 4])};   // digit 1 shows bits 3:0
      return f;
   endfunction

   // frame monitor samples on the falling clk edge where outputs are settled
   always @(negedge clk) begin
      if (!rst_n) begin
         frame_q.delete();
         shreg = '0;
         prev_sck = 1'b0;
         prev_busy = 1'b0;
         prev_load = 1'b0;
         run_len = 0;
         rise_cnt = 0;
         load_len = 0;
         high_min = 1000;
         high_max = 0;
         low_min = 1000;
         low_max = 0;
         rise_min = 1000;
         rise_max = 0;
         load_min = 1000;
         load_max = 0;
         load_overlap = 0;
      end else begin
         if (max_clk != prev_sck) begin
            if (prev_sck) begin
               high_min = (run_len < high_min) ? run_len : high_min;
               high_max = (run_len > high_max) ? run_len : high_max;
            end else begin
               low_min = (run_len < low_min) ? run_len : low_min;
               low_max = (run_len > low_max) ? run_len : low_max;
               shreg = {shreg[`MAX_FRAME_BITS-2:0], max_din};   // chip samples here
               rise_cnt++;
            end
            run_len = 1;
         end else if (dut_busy && !prev_busy) begin
            run_len = 1;                                       // first low phase starts
         end else begin
            run_len++;
         end
         if (max_load) begin
            load_len++;
            if (dut_busy || max_clk) load_overlap++;
            if (!prev_load) begin
               frame_q.push_back(max7219_pkg::frame_t'(shreg));
               rise_min = (rise_cnt < rise_min) ? rise_cnt : rise_min;
               rise_max = (rise_cnt > rise_max) ? rise_cnt : rise_max;
               rise_cnt = 0;
            end
         end else if (prev_load) begin
            load_min = (load_len < load_min) ? load_len : load_min;
            load_max = (load_len > load_max) ? load_len : load_max;
            load_len = 0;
         end
         prev_sck = max_clk;
         prev_busy = dut_busy;
         prev_load = max_load;
      end
   end

   task automatic abort_run(input string why);
      $display("timeout: %s", why);
      $display("checks %0d, errors %0d", check_count, error_count);
      $display("RESULT: FAIL");
      $finish;
   endtask

   task automatic report_test(input string name, input int errs_before);
      $display("test %-14s %s", name, (error_count == errs_before) ? "passed" : "failed");
   endtask

   task automatic next_frame(output max7219_pkg::frame_t f);
      int waited;
      waited = 0;
      do begin
         @(posedge clk);
         waited++;
      end while (frame_q.size() == 0 && waited < FRAME_TIMEOUT);
      if (frame_q.size() == 0) abort_run("no load pulse seen while waiting for a frame");
      else f = frame_q.pop_front();
   endtask

   // digits 1 to 8 with display_value changed right after digit change_after
   task automatic check_scan(input logic [31:0] old_v, input int change_after,
                             input logic [31:0] new_v);
      max7219_pkg::frame_t f;
      int                  d;
      for (d = 1; d <= `MAX_DIGITS; d++) begin
         next_frame(f);
         check_frame($sformatf("digit %0d frame", d), f, digit_frame(old_v, d));
         if (d == change_after) begin
            @(negedge clk);
            display_value = new_v;
         end
      end
   endtask

   task automatic skip_to_scan_end();
      max7219_pkg::frame_t f;
      int                  n;
      n = 0;
      do begin
         next_frame(f);
         n++;
      end while (f.addr != max7219_pkg::reg_digit7 && n < 10);
      if (f.addr != max7219_pkg::reg_digit7) begin
         error_count++;
         $display("no digit 8 frame came within ten frames");
      end
   endtask

   task automatic reset_behavior();
      int errs;
      errs = error_count;
      rst_n = 1'b0;
      repeat (8) @(negedge clk);
      check_bit("max_din", max_din, 1'b0);
      check_bit("max_clk", max_clk, 1'b0);
      check_bit("max_load", max_load, 1'b0);
      check_state(max7219_pkg::st_start);
      repeat (8) @(negedge clk);
      rst_n = 1'b1;
      #1;
      check_state(max7219_pkg::st_start);
      @(negedge clk);
      check_bit("max_din", max_din, 1'b0);
      check_bit("max_clk", max_clk, 1'b0);
      check_bit("max_load", max_load, 1'b0);
      report_test("reset", errs);
   endtask

   task automatic init_sequence();
      max7219_pkg::frame_t f;
      int                  errs;
      int                  i;
      errs = error_count;
      for (i = 0; i < `MAX_INIT_FRAMES; i++) begin
         next_frame(f);
         check_frame($sformatf("init frame %0d", i), f, init_frame_exp(i));
      end
      report_test("init sequence", errs);
   endtask

   task automatic digit_scan();
      logic [31:0] v;
      int          errs;
      errs = error_count;
      v = take_bits(32);
      @(posedge clk);
      @(negedge clk);
      display_value = v;
      skip_to_scan_end();
      check_scan(v, 0, v);
      report_test("digit scan", errs);
   endtask

   task automatic no_tearing();
      logic [31:0] cur;
      logic [31:0] nv;
      int          errs;
      int          it;
      int          k;
      errs = error_count;
      cur = display_value;
      for (it = 0; it < 4; it++) begin
         k = 1 + int'(take_bits(3) % 7);
         nv = take_bits(32);
         check_scan(cur, k, nv);
         cur = nv;
      end
      check_scan(cur, 0, cur);
      report_test("no tearing", errs);
   endtask

   task automatic serial_timing();
      max7219_pkg::frame_t f;
      int                  errs;
      errs = error_count;
      next_frame(f);
      next_frame(f);
      repeat (2) @(posedge clk);     // let the monitor see the one-clk load pulse fall
      check_int("sck high min", high_min, `MAX_SCK_HALF);
      check_int("sck high max", high_max, `MAX_SCK_HALF);
      check_int("sck low min", low_min, `MAX_SCK_HALF);
      check_int("sck low max", low_max, `MAX_SCK_HALF);
      check_int("rising edges min", rise_min, `MAX_FRAME_BITS);
      check_int("rising edges max", rise_max, `MAX_FRAME_BITS);
      check_int("max_load width min", load_min, 1);
      check_int("max_load width max", load_max, 1);
      check_int("max_load during shift", load_overlap, 0);
      report_test("serial timing", errs);
   endtask

   initial begin
      rst_n = 1'b0;
      display_value = take_bits(32);
      reset_behavior();
      init_sequence();
      digit_scan();
      no_tearing();
      serial_timing();
      $display("checks %0d, errors %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* verilog.f */
+incdir+common
+incdir+test
common/max7219_pkg.sv
logic/sck_timer.sv
logic/frame_source.sv
max7219/frame_shifter.sv
max7219/max7219_seq.sv
max7219/max7219_display.sv
test/tb_max7219.sv

/* run.sh */
#!/bin/sh
# build the max7219 testbench with verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f verilog.f --top-module tb_max7219 \
   -o tb_max7219 > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_max7219 > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log
grep -q "RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "simulation gave no result"; exit 1; }
echo "simulation passed"
